// File: PathORAMBackend.f
+incdir+source
source/PathORAMPkg.sv
source/PathAddressGen.sv
source/PathController.sv
source/LaneDispatcher.sv
source/CipherLane.sv
source/LaneCollector.sv
source/PathORAMBackend.sv
testbench/PathORAMBackendTb.sv

// File: run.sh
#!/usr/bin/env bash
# Verilator build and run of the Path ORAM backend testbench

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=PathORAMBackendTb

verilator --binary --timing --assert -Wno-fatal \
	--top-module "$TOP" -Mdir "$BUILD_DIR" -o "$TOP" \
	-f PathORAMBackend.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG_FILE" 2>&1
runStatus=$?
cat "$LOG_FILE"
if [ $runStatus -ne 0 ]; then
	echo "Simulation exited with status $runStatus"
	exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG_FILE"; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed"
exit 1

// File: source/CipherLane.sv
//--------------------------------------------------------------------------
// One pad lane, two mixing rounds over two pipeline stages
//--------------------------------------------------------------------------
`default_nettype none
`include "PathORAMBackend_defines.svh"

module CipherLane #(
	parameter int LaneIndex = 0
) (
	input logic clock,
	input logic reset,
	input logic advance,
	input PathORAMPkg::LaneSlice slice,
	input logic [31:0] seed,
	input logic inValid,
	output PathORAMPkg::LaneSlice outSlice,
	output logic outValid
);
	import PathORAMPkg::*;

	// Lane constant keeps the lane pads apart
	localparam logic [31:0] LaneConst = 32'h9E37_79B9 * (LaneIndex + 1);

	// Rotate, add key, fold in a rotated copy
	function automatic logic [31:0] mixRound(input logic [31:0] value,
			input logic [31:0] roundKey);
		logic [31:0] rotated;
		logic [31:0] summed;
		rotated = {value[26:0], value[31:27]};
		summed = rotated + roundKey;
		return summed ^ {summed[18:0], summed[31:19]};
	endfunction

	logic [31:0] mixStage;
	LaneSlice sliceStage;
	logic validStage;
	logic [31:0] mixFinal;
	LaneSlice pad;

	// Second round keyed with the swapped halves of the lane constant
	always_comb begin
		mixFinal = mixRound(mixStage, {LaneConst[15:0], LaneConst[31:16]});
		pad = mixFinal[`LaneWidth-1:0] ^ mixFinal[31 -: `LaneWidth];
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			validStage <= 1'b0;
			outValid <= 1'b0;
		end else if (advance) begin
			validStage <= inValid;
			outValid <= validStage;
		end
	end

	// Slice delayed to meet its pad
	always_ff @(posedge clock) begin
		if (advance) begin
			mixStage <= mixRound(seed, LaneConst);
			sliceStage <= slice;
			outSlice <= sliceStage ^ pad;
		end
	end
endmodule

`default_nettype wire

// File: source/LaneCollector.sv
//--------------------------------------------------------------------------
// Cipher pipe output stage, joins lane slices and drives back-pressure
//--------------------------------------------------------------------------
`default_nettype none
`include "PathORAMBackend_defines.svh"

module LaneCollector (
	input logic clock,
	input logic reset,
	input PathORAMPkg::LaneSlice [`CipherLanes-1:0] slices,
	input logic sliceValid,
	input PathORAMPkg::BucketWord header,
	output PathORAMPkg::CipherWord outWord,
	output logic outValid,
	input logic outReady,
	output logic advance
);
	import PathORAMPkg::*;

	// Header delay matching the two lane stages
	BucketWord headerDelay;
	BucketWord headerAligned;

	// Whole pipe stalls while a word waits here
	assign advance = !outValid || outReady;

	always_ff @(posedge clock) begin
		if (reset) begin
			outValid <= 1'b0;
		end else if (advance) begin
			outValid <= sliceValid;
		end
	end

	always_ff @(posedge clock) begin
		if (advance) begin
			headerDelay <= header;
			headerAligned <= headerDelay;
			outWord.word.nonce <= headerAligned.nonce;
			outWord.word.record <= slices;
			outWord.index <= BucketIndex'(headerAligned.record.addr);
		end
	end
endmodule

`default_nettype wire

// File: source/LaneDispatcher.sv
//--------------------------------------------------------------------------
// Cipher pipe input stage, splits a bucket word over the lanes
//--------------------------------------------------------------------------
`default_nettype none
`include "PathORAMBackend_defines.svh"

module LaneDispatcher (
	input logic clock,
	input logic reset,
	input logic advance,
	input PathORAMPkg::CipherWord inWord,
	input logic inValid,
	output PathORAMPkg::LaneSlice [`CipherLanes-1:0] slices,
	output logic [31:0] seed,
	output PathORAMPkg::BucketWord header,
	output logic stageValid
);
	import PathORAMPkg::*;

	always_ff @(posedge clock) begin
		if (reset) begin
			stageValid <= 1'b0;
		end else if (advance) begin
			stageValid <= inValid;
		end
	end

	always_ff @(posedge clock) begin
		if (advance) begin
			// Payload slices, lane 0 takes the low bits
			slices <= inWord.word.record;
			// Shared seed from key, bucket and nonce
			seed <= `CipherKey ^ {inWord.word.nonce, 3'b000, inWord.index,
				~inWord.word.nonce, 3'b101, inWord.index};
			// Clear nonce rides alongside
			header.nonce <= inWord.word.nonce;
			// Bucket index carried in the header address field
			header.record <= '0;
			header.record.addr <= PAddr'(inWord.index);
		end
	end
endmodule

`default_nettype wire

// File: source/PathAddressGen.sv
//--------------------------------------------------------------------------
// Bucket index generator for one root-to-leaf path
//--------------------------------------------------------------------------
`default_nettype none
`include "PathORAMBackend_defines.svh"

module PathAddressGen (
	input logic clock,
	input logic reset,
	// Restart at the root with a new leaf
	input logic start,
	input PathORAMPkg::Leaf leaf,
	// One level toward the leaf
	input logic step,
	output PathORAMPkg::BucketIndex bucketIndex,
	output logic lastLevel
);
	import PathORAMPkg::*;

	// Counter parks one past the leaf level when a pass is over
	localparam int LevelWidth = $clog2(`ORAML + 2);

	Leaf leafReg;
	logic leafHeld;
	logic [LevelWidth-1:0] level;
	BucketIndex levelBase;
	BucketIndex levelOffset;

	always_ff @(posedge clock) begin
		if (reset) begin
			level <= LevelWidth'(`ORAML + 1);
		end else if (start) begin
			level <= '0;
		end else if (step) begin
			level <= level + 1'b1;
		end
	end

	// Read pass start takes the leaf, the write pass start reuses it
	always_ff @(posedge clock) begin
		if (reset) begin
			leafHeld <= 1'b0;
		end else if (start) begin
			leafHeld <= !leafHeld;
		end
	end

	// Leaf held for the whole command
	always_ff @(posedge clock) begin
		if (start && !leafHeld) begin
			leafReg <= leaf;
		end
	end

	// First bucket of level i is 2^i - 1
	// Upper i leaf bits pick the bucket inside the level
	always_comb begin
		levelBase = BucketIndex'((1 << level) - 1);
		levelOffset = BucketIndex'(leafReg >> (`ORAML - level));
	end

	assign bucketIndex = levelBase + levelOffset;
	assign lastLevel = (level == LevelWidth'(`ORAML));

	// Controller restarts the generator before stepping beyond the leaf
	assert property (@(posedge clock) disable iff (reset)
		step |-> level <= LevelWidth'(`ORAML));
endmodule

`default_nettype wire

// File: source/PathController.sv
//--------------------------------------------------------------------------
// Backend FSM for path read, block search, path write-back and replies
//--------------------------------------------------------------------------
`default_nettype none
`include "PathORAMBackend_defines.svh"

module PathController (
	input logic clock,
	input logic reset,
	// Frontend
	input PathORAMPkg::BackendCommand command,
	input logic commandValid,
	output logic commandReady,
	output PathORAMPkg::FrontData loadData,
	output logic loadHit,
	output logic loadValid,
	input logic loadReady,
	// DRAM
	output PathORAMPkg::DRAMCmd dramCommand,
	output logic dramCommandValid,
	input logic dramCommandReady,
	input PathORAMPkg::BucketWord dramReadData,
	input logic dramReadDataValid,
	output logic dramReadDataReady,
	output PathORAMPkg::BucketWord dramWriteData,
	output logic dramWriteDataValid,
	input logic dramWriteDataReady,
	// Address generator
	output logic pathStart,
	output logic pathStep,
	input PathORAMPkg::BucketIndex bucketIndex,
	input logic lastLevel,
	// Cipher pipe
	output PathORAMPkg::CipherWord cipherIn,
	output logic cipherInValid,
	input logic advance,
	input PathORAMPkg::CipherWord cipherOut,
	input logic cipherOutValid,
	output logic cipherOutReady
);
	import PathORAMPkg::*;

	localparam int PathLength = `ORAML + 1;
	localparam int CountWidth = $clog2(PathLength + 1);

	CtrlState state;
	CtrlState nextState;
	BackendCommand cmdReg;
	// Words pushed into and taken out of the cipher in this pass
	logic [CountWidth-1:0] feedCount;
	logic [CountWidth-1:0] drainCount;
	logic cmdDone;
	logic passFed;
	logic passDrained;
	logic readPass;
	logic drainHandshake;
	// Decrypted path, one record and one nonce per level
	BlockRecord pathBuf [PathLength];
	Nonce nonceBuf [PathLength];
	logic hitFound;
	logic freeFound;
	logic [CountWidth-1:0] hitSlot;
	logic [CountWidth-1:0] freeSlot;
	BlockRecord feedRecord;

	assign passFed = (feedCount == CountWidth'(PathLength));
	assign passDrained = (drainCount == CountWidth'(PathLength));
	assign readPass = (state == ReadIssue) || (state == ReadWait);
	assign drainHandshake = cipherOutValid && cipherOutReady;

	//--------------------------------------------------------------------------
	// Block search over the path buffer
	//--------------------------------------------------------------------------

	// Walk from the leaf up so the slot nearest the root wins
	always_comb begin
		hitFound = 1'b0;
		freeFound = 1'b0;
		hitSlot = '0;
		freeSlot = '0;
		for (int i = PathLength - 1; i >= 0; i--) begin
			if (pathBuf[i].valid && pathBuf[i].addr == cmdReg.addr) begin
				hitFound = 1'b1;
				hitSlot = CountWidth'(i);
			end
			if (!pathBuf[i].valid) begin
				freeFound = 1'b1;
				freeSlot = CountWidth'(i);
			end
		end
	end

	// Write lands on the matching slot, else on the first empty one
	always_comb begin
		feedRecord = pathBuf[feedCount];
		if (cmdReg.op == OpWrite && (hitFound || freeFound) &&
				feedCount == (hitFound ? hitSlot : freeSlot)) begin
			feedRecord.valid = 1'b1;
			feedRecord.addr = cmdReg.addr;
			feedRecord.data = cmdReg.data;
		end
	end

	assign loadHit = hitFound;
	assign loadData = hitFound ? pathBuf[hitSlot].data : '0;

	// Read pass passes DRAM words through, write pass sends re-keyed records
	always_comb begin
		cipherIn.index = bucketIndex;
		if (state == WriteIssue) begin
			cipherIn.word.nonce = nonceBuf[feedCount] + Nonce'(1);
			cipherIn.word.record = feedRecord;
		end else begin
			cipherIn.word = dramReadData;
		end
	end

	// Encrypted words go straight to DRAM in the write pass
	assign dramWriteData = cipherOut.word;
	assign dramWriteDataValid = (state == WriteIssue) && cipherOutValid;
	assign cipherOutReady = (state == WriteIssue) ? dramWriteDataReady : 1'b1;

	//--------------------------------------------------------------------------
	// FSM
	//--------------------------------------------------------------------------

	always_comb begin
		nextState = state;
		commandReady = 1'b0;
		dramCommandValid = 1'b0;
		dramReadDataReady = 1'b0;
		cipherInValid = 1'b0;
		loadValid = 1'b0;
		pathStart = 1'b0;
		pathStep = 1'b0;
		dramCommand.address = `DDRAWidth'(bucketIndex);
		dramCommand.isWrite = (state == WriteIssue);
		case (state)
			Idle: begin
				commandReady = 1'b1;
				if (commandValid) begin
					pathStart = 1'b1;
					nextState = ReadIssue;
				end
			end
			ReadIssue: begin
				dramCommandValid = 1'b1;
				if (dramCommandReady) begin
					nextState = ReadWait;
				end
			end
			// One bucket in flight, so the generator still holds its index
			ReadWait: begin
				if (!passFed) begin
					dramReadDataReady = advance;
					cipherInValid = dramReadDataValid;
					if (dramReadDataValid && advance) begin
						pathStep = 1'b1;
						if (!lastLevel) begin
							nextState = ReadIssue;
						end
					end
				end else if (passDrained) begin
					pathStart = 1'b1;
					nextState = WriteIssue;
				end
			end
			// Write command first, then its record into the cipher
			WriteIssue: begin
				if (!passFed) begin
					if (!cmdDone) begin
						dramCommandValid = 1'b1;
					end else begin
						cipherInValid = 1'b1;
						pathStep = advance;
					end
				end else if (passDrained) begin
					nextState = (cmdReg.op == OpRead) ? Reply : Idle;
				end
			end
			Reply: begin
				loadValid = 1'b1;
				if (loadReady) begin
					nextState = Idle;
				end
			end
			default: nextState = Idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= Idle;
			feedCount <= '0;
			drainCount <= '0;
			cmdDone <= 1'b0;
		end else begin
			state <= nextState;
			if (pathStart) begin
				feedCount <= '0;
				drainCount <= '0;
				cmdDone <= 1'b0;
			end else begin
				if (cipherInValid && advance) begin
					feedCount <= feedCount + 1'b1;
				end
				if (drainHandshake) begin
					drainCount <= drainCount + 1'b1;
				end
				if (state == WriteIssue && dramCommandValid && dramCommandReady) begin
					cmdDone <= 1'b1;
				end else if (pathStep) begin
					cmdDone <= 1'b0;
				end
			end
		end
	end

	// Never-written buckets read back as empty
	always_ff @(posedge clock) begin
		if (state == Idle && commandValid) begin
			cmdReg <= command;
		end
		if (drainHandshake && readPass) begin
			pathBuf[drainCount] <= (cipherOut.word.nonce == '0) ? '0 : cipherOut.word.record;
			nonceBuf[drainCount] <= cipherOut.word.nonce;
		end
	end

	// Command accepted only from Idle, and it starts a read pass
	assert property (@(posedge clock) disable iff (reset)
		commandValid && commandReady |=> state == ReadIssue && !commandReady);

	// Cipher returns no more decrypted words than the path holds
	assert property (@(posedge clock) disable iff (reset)
		drainHandshake && readPass |-> drainCount < CountWidth'(PathLength));
endmodule

`default_nettype wire

// File: source/PathORAMBackend.sv
//--------------------------------------------------------------------------
// Backend top with controller, path address generator and cipher lanes
//--------------------------------------------------------------------------
`default_nettype none
`include "PathORAMBackend_defines.svh"

module PathORAMBackend (
	input logic clock,
	input logic reset,
	// Frontend command and load channels
	input PathORAMPkg::BackendCommand command,
	input logic commandValid,
	output logic commandReady,
	output PathORAMPkg::FrontData loadData,
	output logic loadHit,
	output logic loadValid,
	input logic loadReady,
	// DRAM command, read and write channels
	output PathORAMPkg::DRAMCmd dramCommand,
	output logic dramCommandValid,
	input logic dramCommandReady,
	input PathORAMPkg::BucketWord dramReadData,
	input logic dramReadDataValid,
	output logic dramReadDataReady,
	output PathORAMPkg::BucketWord dramWriteData,
	output logic dramWriteDataValid,
	input logic dramWriteDataReady
);
	import PathORAMPkg::*;

	//--------------------------------------------------------------------------
	// Wires
	//--------------------------------------------------------------------------

	logic pathStart;
	logic pathStep;
	BucketIndex bucketIndex;
	logic lastLevel;

	CipherWord cipherIn;
	logic cipherInValid;
	CipherWord cipherOut;
	logic cipherOutValid;
	logic cipherOutReady;
	logic advance;

	LaneSlice [`CipherLanes-1:0] dispatchSlices;
	LaneSlice [`CipherLanes-1:0] laneSlices;
	logic [`CipherLanes-1:0] laneValid;
	logic [31:0] laneSeed;
	BucketWord laneHeader;
	logic stageValid;

	//--------------------------------------------------------------------------
	// Control and addressing
	//--------------------------------------------------------------------------

	PathController controller (
		.clock(clock), .reset(reset),
		.command(command), .commandValid(commandValid), .commandReady(commandReady),
		.loadData(loadData), .loadHit(loadHit),
		.loadValid(loadValid), .loadReady(loadReady),
		.dramCommand(dramCommand), .dramCommandValid(dramCommandValid),
		.dramCommandReady(dramCommandReady),
		.dramReadData(dramReadData), .dramReadDataValid(dramReadDataValid),
		.dramReadDataReady(dramReadDataReady),
		.dramWriteData(dramWriteData), .dramWriteDataValid(dramWriteDataValid),
		.dramWriteDataReady(dramWriteDataReady),
		.pathStart(pathStart), .pathStep(pathStep),
		.bucketIndex(bucketIndex), .lastLevel(lastLevel),
		.cipherIn(cipherIn), .cipherInValid(cipherInValid), .advance(advance),
		.cipherOut(cipherOut), .cipherOutValid(cipherOutValid),
		.cipherOutReady(cipherOutReady)
	);

	PathAddressGen addressGen (
		.clock(clock), .reset(reset),
		.start(pathStart), .leaf(command.leaf), .step(pathStep),
		.bucketIndex(bucketIndex), .lastLevel(lastLevel)
	);

	//--------------------------------------------------------------------------
	// Cipher pipe
	//--------------------------------------------------------------------------

	LaneDispatcher dispatcher (
		.clock(clock), .reset(reset), .advance(advance),
		.inWord(cipherIn), .inValid(cipherInValid),
		.slices(dispatchSlices), .seed(laneSeed),
		.header(laneHeader), .stageValid(stageValid)
	);

	for (genvar laneIndex = 0; laneIndex < `CipherLanes; laneIndex++) begin : lanes
		CipherLane #(.LaneIndex(laneIndex)) lane (
			.clock(clock), .reset(reset), .advance(advance),
			.slice(dispatchSlices[laneIndex]), .seed(laneSeed), .inValid(stageValid),
			.outSlice(laneSlices[laneIndex]), .outValid(laneValid[laneIndex])
		);
	end

	// Lanes run in lockstep
	LaneCollector collector (
		.clock(clock), .reset(reset),
		.slices(laneSlices), .sliceValid(&laneValid), .header(laneHeader),
		.outWord(cipherOut), .outValid(cipherOutValid), .outReady(cipherOutReady),
		.advance(advance)
	);
endmodule

`default_nettype wire

// File: source/PathORAMBackend_defines.svh
//--------------------------------------------------------------------------
// Tree geometry, datapath widths and cipher constants of the ORAM backend
//--------------------------------------------------------------------------
`ifndef PATH_ORAM_BACKEND_DEFINES_SVH
`define PATH_ORAM_BACKEND_DEFINES_SVH

// Tree has ORAML+1 levels from root to leaf
`define ORAML 4
// Block address and frontend data widths
`define ORAMU 7
`define FEDWidth 48
// Per-bucket nonce and DRAM address widths
`define NonceWidth 8
`define DDRAWidth 8
// Enough bits for 2^(ORAML+1)-1 buckets
`define BucketIndexWidth 5
// Block record payload, split evenly over the cipher lanes
`define PayloadWidth (1 + `ORAMU + `FEDWidth)
`define CipherLanes 4
`define LaneWidth (`PayloadWidth / `CipherLanes)
`define CipherKey 32'h6B3D_A51C

`endif

// File: source/PathORAMPkg.sv
//--------------------------------------------------------------------------
// Shared vector types, bus structs and state encodings of the backend
//--------------------------------------------------------------------------
`default_nettype none
`include "PathORAMBackend_defines.svh"

package PathORAMPkg;
	// Vector types
	typedef logic [`ORAMU-1:0] PAddr;
	typedef logic [`ORAML-1:0] Leaf;
	typedef logic [`BucketIndexWidth-1:0] BucketIndex;
	typedef logic [`NonceWidth-1:0] Nonce;
	typedef logic [`FEDWidth-1:0] FrontData;
	typedef logic [`LaneWidth-1:0] LaneSlice;

	typedef enum logic {OpRead, OpWrite} Op;

	// One block per bucket, the encrypted part of a DRAM word
	typedef struct packed {
		logic valid;
		PAddr addr;
		FrontData data;
	} BlockRecord;

	// DRAM data word with the nonce kept in clear
	typedef struct packed {
		Nonce nonce;
		BlockRecord record;
	} BucketWord;

	typedef struct packed {
		Op op;
		PAddr addr;
		Leaf leaf;
		FrontData data;
	} BackendCommand;

	typedef struct packed {
		logic [`DDRAWidth-1:0] address;
		logic isWrite;
	} DRAMCmd;

	// Unit that travels through the cipher lanes
	typedef struct packed {
		BucketWord word;
		BucketIndex index;
	} CipherWord;

	typedef enum logic [2:0] {Idle, ReadIssue, ReadWait, WriteIssue, Reply} CtrlState;
endpackage

`default_nettype wire

// File: testbench/PathORAMBackendTb.sv
//--------------------------------------------------------------------------
// Testbench for the ORAM backend with a DRAM model, file driven commands
// and checks of path order, nonces, ciphertext and load replies
//--------------------------------------------------------------------------
`default_nettype none
`include "PathORAMBackend_defines.svh"

module PathORAMBackendTb;
	import PathORAMPkg::*;

	localparam int TreeSize = 32;
	localparam int PathLength = `ORAML + 1;
	localparam int CyclesPerCommand = 200;
	localparam int LoadStallCycles = 4;

	// One command line of the stimulus file
	typedef struct packed {
		logic isWrite;
		PAddr addr;
		Leaf leaf;
		FrontData data;
		FrontData expData;
		logic expHit;
	} StimEntry;

	logic clock;
	logic reset;
	BackendCommand command;
	logic commandValid;
	logic commandReady;
	FrontData loadData;
	logic loadHit;
	logic loadValid;
	logic loadReady;
	DRAMCmd dramCommand;
	logic dramCommandValid;
	logic dramCommandReady;
	BucketWord dramReadData;
	logic dramReadDataValid;
	logic dramReadDataReady;
	BucketWord dramWriteData;
	logic dramWriteDataValid;
	logic dramWriteDataReady;

	// DRAM model and per-command bookkeeping
	BucketWord memory [TreeSize];
	int readQueue [$];
	int writeQueue [$];
	int readsServed;
	BackendCommand latchedCmd;
	int dramCmdCount;
	int writeDataCount;

	integer seed;
	int cycleCount;
	int cycleLimit;
	int dramChecks;
	int dramErrors;
	int replyChecks;
	int replyErrors;
	StimEntry stimList [$];

	PathORAMBackend DUT (
		.clock(clock), .reset(reset),
		.command(command), .commandValid(commandValid), .commandReady(commandReady),
		.loadData(loadData), .loadHit(loadHit), .loadValid(loadValid), .loadReady(loadReady),
		.dramCommand(dramCommand), .dramCommandValid(dramCommandValid),
		.dramCommandReady(dramCommandReady),
		.dramReadData(dramReadData), .dramReadDataValid(dramReadDataValid),
		.dramReadDataReady(dramReadDataReady),
		.dramWriteData(dramWriteData), .dramWriteDataValid(dramWriteDataValid),
		.dramWriteDataReady(dramWriteDataReady)
	);

	// Level i of a path starts at bucket 2^i - 1
	function automatic int bucketOnPath(input Leaf leaf, input int level);
		return ((1 << level) - 1) + (int'(leaf) >> (`ORAML - level));
	endfunction

	task automatic reportCounts();
		$display("Checks: %0d DRAM, %0d reply; errors: %0d DRAM, %0d reply",
			dramChecks, replyChecks, dramErrors, replyErrors);
	endtask

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	//--------------------------------------------------------------------------
	// DRAM model, sampled on the rising edge
	//--------------------------------------------------------------------------

	always @(posedge clock) begin : dramModel
		int index;
		int expectedIndex;
		logic expectedWrite;
		Nonce expectedNonce;
		BlockRecord plainRecord;
		if (reset) begin
			for (int i = 0; i < TreeSize; i++) begin
				memory[i] = '0;
			end
			readQueue.delete();
			writeQueue.delete();
			readsServed = 0;
			dramCmdCount = 0;
			writeDataCount = 0;
			cycleCount = 0;
			dramChecks = 0;
			dramErrors = 0;
		end else if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
			$display("Timeout after %0d cycles, the DUT stopped finishing commands", cycleCount);
			reportCounts();
			$display("TEST RESULT: FAIL");
			$finish;
		end else begin
			cycleCount++;
			// New command restarts the path bookkeeping
			if (commandValid && commandReady) begin
				latchedCmd = command;
				dramCmdCount = 0;
				writeDataCount = 0;
			end
			// Five reads then five writes along the path
			if (dramCommandValid && dramCommandReady) begin
				expectedIndex = bucketOnPath(latchedCmd.leaf, dramCmdCount % PathLength);
				expectedWrite = (dramCmdCount >= PathLength);
				dramChecks++;
				assert (int'(dramCommand.address) == expectedIndex &&
						dramCommand.isWrite == expectedWrite) else begin
					dramErrors++;
					$display("[FAIL] pathOrder step %0d: expected %0d/%0b, actual %0d/%0b",
						dramCmdCount, expectedIndex, expectedWrite,
						dramCommand.address, dramCommand.isWrite);
				end
				index = int'(dramCommand.address) % TreeSize;
				if (dramCommand.isWrite) begin
					writeQueue.push_back(index);
				end else begin
					readQueue.push_back(index);
				end
				dramCmdCount++;
			end
			if (dramReadDataValid && dramReadDataReady) begin
				void'(readQueue.pop_front());
				readsServed++;
			end
			if (dramWriteDataValid && dramWriteDataReady) begin
				dramChecks++;
				assert (writeQueue.size() != 0) else begin
					dramErrors++;
					$display("Write data arrived with no write command pending");
				end
				if (writeQueue.size() != 0) begin
					index = writeQueue.pop_front();
					// Stored nonce is still the one the read pass saw
					expectedNonce = memory[index].nonce + Nonce'(1);
					dramChecks++;
					assert (dramWriteData.nonce == expectedNonce) else begin
						dramErrors++;
						$display("[FAIL] nonceIncrement bucket %0d: expected %h, actual %h",
							index, expectedNonce, dramWriteData.nonce);
					end
					if (latchedCmd.op == OpWrite) begin
						plainRecord.valid = 1'b1;
						plainRecord.addr = latchedCmd.addr;
						plainRecord.data = latchedCmd.data;
						dramChecks++;
						assert (dramWriteData.record != plainRecord) else begin
							dramErrors++;
							$display("[FAIL] encryption bucket %0d: expected not %h, actual %h",
								index, plainRecord, dramWriteData.record);
						end
					end
					memory[index] = dramWriteData;
					writeDataCount++;
				end
			end
			if (loadValid) begin
				dramChecks++;
				assert (latchedCmd.op == OpRead) else begin
					dramErrors++;
					$display("Load reply raised during a write command");
				end
			end
		end
	end

	// Random stalls on both readies and on read data, driven on the falling edge
	initial begin : dramDriver
		int offered;
		seed = 32'ha692;
		offered = 0;
		dramCommandReady = 1'b0;
		dramReadDataValid = 1'b0;
		dramReadData = '0;
		dramWriteDataReady = 1'b0;
		forever begin
			@(negedge clock);
			dramCommandReady = (($random(seed) & 3) != 0);
			dramWriteDataReady = (($random(seed) & 3) != 0);
			// Offered word stays up until it is taken
			if (!dramReadDataValid || readsServed != offered) begin
				offered = readsServed;
				dramReadDataValid = (readQueue.size() != 0) && (($random(seed) & 3) != 0);
				dramReadData = dramReadDataValid ? memory[readQueue[0]] : '0;
			end
		end
	end

	//--------------------------------------------------------------------------
	// Frontend commands and reply checks
	//--------------------------------------------------------------------------

	task automatic takeLoad(input StimEntry entry);
		FrontData heldData;
		logic heldHit;
		logic seen;
		seen = 1'b0;
		while (!seen) begin
			@(posedge clock);
			seen = loadValid;
		end
		heldData = loadData;
		heldHit = loadHit;
		// Reply frozen while loadReady is low
		repeat (LoadStallCycles) begin
			@(posedge clock);
			replyChecks++;
			assert (loadValid && loadData == heldData && loadHit == heldHit) else begin
				replyErrors++;
				$display("[FAIL] loadHold addr %h: expected 1/%h/%0b, actual %0b/%h/%0b",
					entry.addr, heldData, heldHit, loadValid, loadData, loadHit);
			end
		end
		@(negedge clock);
		loadReady = 1'b1;
		@(posedge clock);
		replyChecks += 2;
		assert (loadHit == entry.expHit) else begin
			replyErrors++;
			$display("[FAIL] loadHit addr %h: expected %0b, actual %0b",
				entry.addr, entry.expHit, loadHit);
		end
		assert (loadData == entry.expData) else begin
			replyErrors++;
			$display("[FAIL] loadData addr %h: expected %h, actual %h",
				entry.addr, entry.expData, loadData);
		end
		@(negedge clock);
		loadReady = 1'b0;
	endtask

	task automatic runCommand(input StimEntry entry);
		BackendCommand cmd;
		logic seen;
		cmd.op = entry.isWrite ? OpWrite : OpRead;
		cmd.addr = entry.addr;
		cmd.leaf = entry.leaf;
		cmd.data = entry.data;
		@(negedge clock);
		// Command bits held only until the handshake
		command = cmd;
		commandValid = 1'b1;
		seen = 1'b0;
		while (!seen) begin
			@(posedge clock);
			seen = commandReady;
		end
		@(negedge clock);
		commandValid = 1'b0;
		command = '0;
		if (entry.isWrite) begin
			// Write ends when the DUT is ready again
			seen = 1'b0;
			while (!seen) begin
				@(posedge clock);
				seen = commandReady;
			end
		end else begin
			takeLoad(entry);
		end
		@(negedge clock);
		replyChecks++;
		assert (dramCmdCount == 2 * PathLength && writeDataCount == PathLength) else begin
			replyErrors++;
			$display("[FAIL] pathLength addr %h: expected %0d/%0d, actual %0d/%0d",
				entry.addr, 2 * PathLength, PathLength, dramCmdCount, writeDataCount);
		end
	endtask

	initial begin : stimulus
		int fd;
		string line;
		int fields;
		int op;
		int addr;
		int leaf;
		int expHit;
		FrontData data;
		FrontData expData;
		StimEntry entry;
		reset = 1'b1;
		command = '0;
		commandValid = 1'b0;
		loadReady = 1'b0;
		cycleLimit = 0;
		replyChecks = 0;
		replyErrors = 0;
		fd = $fopen("testbench/PathORAMBackend_stim.txt", "r");
		if (fd == 0) begin
			replyErrors++;
			$display("Could not open the stimulus file");
		end else begin
			while ($fgets(line, fd) != 0) begin
				// Lines starting with # are comments
				if (line.len() > 0 && line.getc(0) != 8'h23) begin
					fields = $sscanf(line, "%h %h %h %h %h %h",
						op, addr, leaf, data, expData, expHit);
					if (fields == 6) begin
						entry.isWrite = (op != 0);
						entry.addr = PAddr'(addr);
						entry.leaf = Leaf'(leaf);
						entry.data = data;
						entry.expData = expData;
						entry.expHit = (expHit != 0);
						stimList.push_back(entry);
					end
				end
			end
			$fclose(fd);
		end
		if (stimList.size() == 0) begin
			replyErrors++;
			$display("No commands found in the stimulus file");
		end
		cycleLimit = stimList.size() * CyclesPerCommand;
		repeat (5) @(negedge clock);
		reset = 1'b0;
		foreach (stimList[i]) begin
			runCommand(stimList[i]);
		end
		@(negedge clock);
		reportCounts();
		if (dramErrors + replyErrors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end
endmodule

`default_nettype wire

// File: testbench/PathORAMBackend_stim.txt
# op addr leaf data expected_data expected_hit, all hex, op 0 read and 1 write
# writes leave the expected columns at zero
0 05 3 000000000000 000000000000 0
1 10 5 a1a1a1a1a1a1 000000000000 0
0 10 5 000000000000 a1a1a1a1a1a1 1
1 11 5 b2b2b2b2b2b2 000000000000 0
1 12 5 c3c3c3c3c3c3 000000000000 0
1 13 5 d4d4d4d4d4d4 000000000000 0
1 14 5 e5e5e5e5e5e5 000000000000 0
1 15 5 f6f6f6f6f6f6 000000000000 0
0 15 5 000000000000 000000000000 0
0 13 5 000000000000 d4d4d4d4d4d4 1
0 14 5 000000000000 e5e5e5e5e5e5 1
1 12 5 0123456789ab 000000000000 0
0 12 5 000000000000 0123456789ab 1
0 11 5 000000000000 b2b2b2b2b2b2 1
1 20 c 5a5a5a5a5a5a 000000000000 0
0 20 c 000000000000 5a5a5a5a5a5a 1
0 7f 9 000000000000 000000000000 0
1 21 4 3c3c3c3c3c3c 000000000000 0
0 21 4 000000000000 3c3c3c3c3c3c 1
1 22 4 777777777777 000000000000 0
0 22 4 000000000000 000000000000 0
1 30 f 89abcdef0123 000000000000 0
0 30 f 000000000000 89abcdef0123 1
1 10 5 fedcba987654 000000000000 0
0 10 5 000000000000 fedcba987654 1
